/* rs_defines.svh */
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// Reservation station geometry

// Entries in the station
`define RS_NUM_ENTRIES 4

// Source operands per micro-op
`define RS_NUM_SOURCES 2

// Datapath width

// Operand and result width
`define RS_XLEN 32

// ROB id width covers 32 in-flight micro-ops
`define RS_ROBID_W 5

`endif

/* rs_pkg.sv */
`include "rs_defines.svh"

package rs_pkg;

    // 3-bit ALU operation encoding
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } t_alu_op;

    // One source operand as seen at dispatch
    typedef struct packed {
        logic                   pending;
        logic [`RS_ROBID_W-1:0] robid;
        logic [`RS_XLEN-1:0]    val;
    } t_src_trk;

    // Dispatch payload written into an entry
    // src[0] is source 1, src[1] is source 2
    typedef struct packed {
        t_alu_op                           op;
        logic [`RS_ROBID_W-1:0]            robid;
        t_src_trk [`RS_NUM_SOURCES-1:0]    src;
    } t_uop_disp;

    // Packet handed from the select stage to the ALU
    typedef struct packed {
        t_alu_op                op;
        logic [`RS_ROBID_W-1:0] robid;
        logic [`RS_XLEN-1:0]    src1_val;
        logic [`RS_XLEN-1:0]    src2_val;
    } t_uop_iss;

    // Result bus broadcast
    typedef struct packed {
        logic                   valid;
        logic [`RS_ROBID_W-1:0] robid;
        logic [`RS_XLEN-1:0]    data;
    } t_result;

endpackage

/* rs_issue_if.sv */
`timescale 1ns/1ps

interface rs_issue_if;
    import rs_pkg::*;

    // Entry holds a micro-op
    logic     valid;
    // Entry has all sources ready
    logic     req;
    // Select picked this entry
    logic     gnt;
    // Operands and op for the ALU
    t_uop_iss pkt;

    modport entry (
        output valid,
        output req,
        output pkt,
        input  gnt
    );

    modport select (
        input  valid,
        input  req,
        input  pkt,
        output gnt
    );

endinterface

/* rs_reg_trk.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_reg_trk (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  rs_pkg::t_src_trk    alloc_src,
    input  rs_pkg::t_result     result,
    output logic                ready,
    output logic                from_grf,
    output logic [`RS_XLEN-1:0] src_data
);

    logic [`RS_ROBID_W-1:0] robid_q;
    logic                   bypass;
    logic                   wake;

    // Producer broadcasting in the same cycle as our allocation
    assign bypass = result.valid && (result.robid == alloc_src.robid);

    // Waiting source sees its producer on the bus
    assign wake = !ready && result.valid && (result.robid == robid_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            ready    <= 1'b0;
            from_grf <= 1'b0;
        end else if (alloc) begin
            ready    <= !alloc_src.pending || bypass;
            from_grf <= !alloc_src.pending;
        end else if (wake) begin
            ready <= 1'b1;
        end
    end

    // Operand value and producer tag
    always_ff @(posedge clk) begin
        if (alloc) begin
            robid_q <= alloc_src.robid;
            // Bus data only matters on a bypass hit, a later wake overwrites it
            if (alloc_src.pending) begin
                src_data <= result.data;
            end else begin
                src_data <= alloc_src.val;
            end
        end else if (wake) begin
            src_data <= result.data;
        end
    end

    // Once woken, a source stays ready until the entry is reused
    a_ready_hold: assert property (
        @(posedge clk) disable iff (reset)
        $fell(ready) |-> $past(alloc)
    ) else $error("rs_reg_trk: ready dropped without a new allocation");

endmodule

/* rs_entry.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_entry (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       alloc,
    input  rs_pkg::t_uop_disp          alloc_uop,
    input  rs_pkg::t_result            result,
    rs_issue_if.entry                  iss,
    output logic [`RS_NUM_SOURCES-1:0] src_from_grf
);
    import rs_pkg::*;

    localparam int SRC1 = 0;
    localparam int SRC2 = 1;

    typedef enum logic {
        IDLE,
        VALID
    } t_ent_state;

    t_ent_state state;
    t_ent_state state_nxt;

    // Static part of the micro-op
    t_alu_op                op_q;
    logic [`RS_ROBID_W-1:0] robid_q;

    logic [`RS_NUM_SOURCES-1:0]               src_ready;
    logic [`RS_NUM_SOURCES-1:0][`RS_XLEN-1:0] src_data;

    // Entry FSM is freed by the grant since nothing replays
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:  if (alloc)   state_nxt = VALID;
            VALID: if (iss.gnt) state_nxt = IDLE;
            default:            state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            op_q    <= alloc_uop.op;
            robid_q <= alloc_uop.robid;
        end
    end

    for (genvar s = 0; s < `RS_NUM_SOURCES; s++) begin : g_src_trk
        rs_reg_trk u_trk (
            .clk       (clk),
            .reset     (reset),
            .alloc     (alloc),
            .alloc_src (alloc_uop.src[s]),
            .result    (result),
            .ready     (src_ready[s]),
            .from_grf  (src_from_grf[s]),
            .src_data  (src_data[s])
        );
    end

    assign iss.valid = (state == VALID);
    assign iss.req   = iss.valid && (&src_ready);
    assign iss.pkt   = '{
        op:       op_q,
        robid:    robid_q,
        src1_val: src_data[SRC1],
        src2_val: src_data[SRC2]
    };

    // Allocation only targets a free entry
    a_alloc_idle: assert property (
        @(posedge clk) disable iff (reset)
        alloc |-> (state == IDLE)
    ) else $error("rs_entry: allocated while busy");

    // Select only grants a requester
    a_gnt_req: assert property (
        @(posedge clk) disable iff (reset)
        iss.gnt |-> iss.req
    ) else $error("rs_entry: grant without request");

endmodule

/* rs_alloc_ctl.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_alloc_ctl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       disp_valid,
    input  logic [`RS_NUM_ENTRIES-1:0] entry_valid,
    output logic [`RS_NUM_ENTRIES-1:0] alloc,
    output logic                       full
);

    logic [`RS_NUM_ENTRIES-1:0] free_vec;
    logic [`RS_NUM_ENTRIES-1:0] first_free;

    assign free_vec = ~entry_valid;

    // Isolate the lowest set bit of the free vector
    assign first_free = free_vec & (~free_vec + 1'b1);

    // One-hot steer of the dispatch strobe
    assign alloc = disp_valid ? first_free : '0;

    assign full = &entry_valid;

    // No back-pressure, so dispatch into a full station is lost
    a_no_disp_full: assert property (
        @(posedge clk) disable iff (reset)
        !(disp_valid && full)
    ) else $error("rs_alloc_ctl: dispatch while station is full");

endmodule

/* rs_issue_select.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_issue_select (
    input  logic             clk,
    input  logic             reset,
    rs_issue_if.select       iss [`RS_NUM_ENTRIES],
    output logic             iss_valid,
    output rs_pkg::t_uop_iss iss_pkt
);
    import rs_pkg::*;

    logic [`RS_NUM_ENTRIES-1:0] req_vec;
    logic [`RS_NUM_ENTRIES-1:0] valid_vec;
    logic [`RS_NUM_ENTRIES-1:0] gnt_vec;
    t_uop_iss                   pkt_arr [`RS_NUM_ENTRIES];
    t_uop_iss                   pkt_sel;

    for (genvar e = 0; e < `RS_NUM_ENTRIES; e++) begin : g_port
        assign req_vec[e]   = iss[e].req;
        assign valid_vec[e] = iss[e].valid;
        assign pkt_arr[e]   = iss[e].pkt;
        assign iss[e].gnt   = gnt_vec[e];
    end

    // Fixed priority where the lowest index wins
    assign gnt_vec = req_vec & (~req_vec + 1'b1);

    always_comb begin
        pkt_sel = '0;
        for (int e = 0; e < `RS_NUM_ENTRIES; e++) begin
            if (gnt_vec[e]) begin
                pkt_sel = pkt_arr[e];
            end
        end
    end

    // Issue register feeding the ALU
    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= |gnt_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (|gnt_vec) begin
            iss_pkt <= pkt_sel;
        end
    end

    // Granted entry is empty in the next cycle
    a_gnt_final: assert property (
        @(posedge clk) disable iff (reset)
        (|gnt_vec) |=> ((valid_vec & $past(gnt_vec)) == '0)
    ) else $error("rs_issue_select: granted entry still occupied");

    // Requests only come from occupied entries
    a_req_occupied: assert property (
        @(posedge clk) disable iff (reset)
        (req_vec & ~valid_vec) == '0
    ) else $error("rs_issue_select: request from an empty entry");

endmodule

/* rs_alu.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_alu (
    input  logic             clk,
    input  logic             reset,
    input  logic             iss_valid,
    input  rs_pkg::t_uop_iss iss_pkt,
    output rs_pkg::t_result  result
);
    import rs_pkg::*;

    localparam int SHAMT_W = $clog2(`RS_XLEN);

    logic [SHAMT_W-1:0]     shamt;
    logic [`RS_XLEN-1:0]    alu_out;
    logic                   res_valid_q;
    logic [`RS_ROBID_W-1:0] res_robid_q;
    logic [`RS_XLEN-1:0]    res_data_q;

    // Shift amount from the low bits of source 2
    assign shamt = iss_pkt.src2_val[SHAMT_W-1:0];

    always_comb begin
        case (iss_pkt.op)
            ALU_ADD: alu_out = iss_pkt.src1_val + iss_pkt.src2_val;
            ALU_SUB: alu_out = iss_pkt.src1_val - iss_pkt.src2_val;
            ALU_AND: alu_out = iss_pkt.src1_val & iss_pkt.src2_val;
            ALU_OR:  alu_out = iss_pkt.src1_val | iss_pkt.src2_val;
            ALU_XOR: alu_out = iss_pkt.src1_val ^ iss_pkt.src2_val;
            ALU_SLL: alu_out = iss_pkt.src1_val << shamt;
            ALU_SRL: alu_out = iss_pkt.src1_val >> shamt;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res_robid_q <= iss_pkt.robid;
            res_data_q  <= alu_out;
        end
    end

    // Broadcast to the trackers and out of the cluster
    assign result = '{valid: res_valid_q, robid: res_robid_q, data: res_data_q};

endmodule

/* rs_top.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_top (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   disp_valid,
    input  rs_pkg::t_alu_op        disp_op,
    input  logic [`RS_ROBID_W-1:0] disp_robid,
    input  logic                   disp_src1_pending,
    input  logic [`RS_ROBID_W-1:0] disp_src1_robid,
    input  logic [`RS_XLEN-1:0]    disp_src1_val,
    input  logic                   disp_src2_pending,
    input  logic [`RS_ROBID_W-1:0] disp_src2_robid,
    input  logic [`RS_XLEN-1:0]    disp_src2_val,

    output logic                   rs_full,

    output logic                   res_valid,
    output logic [`RS_ROBID_W-1:0] res_robid,
    output logic [`RS_XLEN-1:0]    res_data
);
    import rs_pkg::*;

    t_src_trk                   disp_src1;
    t_src_trk                   disp_src2;
    t_uop_disp                  disp_uop;
    t_result                    result;
    logic [`RS_NUM_ENTRIES-1:0] alloc;
    logic [`RS_NUM_ENTRIES-1:0] entry_valid;
    logic                       iss_valid;
    t_uop_iss                   iss_pkt;

    rs_issue_if iss_if [`RS_NUM_ENTRIES] ();

    // Pack the dispatch port
    assign disp_src1 = '{pending: disp_src1_pending, robid: disp_src1_robid, val: disp_src1_val};
    assign disp_src2 = '{pending: disp_src2_pending, robid: disp_src2_robid, val: disp_src2_val};
    assign disp_uop  = '{op: disp_op, robid: disp_robid, src: {disp_src2, disp_src1}};

    rs_alloc_ctl u_alloc_ctl (
        .clk         (clk),
        .reset       (reset),
        .disp_valid  (disp_valid),
        .entry_valid (entry_valid),
        .alloc       (alloc),
        .full        (rs_full)
    );

    for (genvar e = 0; e < `RS_NUM_ENTRIES; e++) begin : g_entry
        rs_entry u_entry (
            .clk          (clk),
            .reset        (reset),
            .alloc        (alloc[e]),
            .alloc_uop    (disp_uop),
            .result       (result),
            .iss          (iss_if[e]),
            .src_from_grf ()
        );
        assign entry_valid[e] = iss_if[e].valid;
    end

    rs_issue_select u_issue_select (
        .clk       (clk),
        .reset     (reset),
        .iss       (iss_if),
        .iss_valid (iss_valid),
        .iss_pkt   (iss_pkt)
    );

    rs_alu u_alu (
        .clk       (clk),
        .reset     (reset),
        .iss_valid (iss_valid),
        .iss_pkt   (iss_pkt),
        .result    (result)
    );

    // Completion stream
    assign res_valid = result.valid;
    assign res_robid = result.robid;
    assign res_data  = result.data;

endmodule

/* tb_rs_top.sv */
`timescale 1ns/1ps
`include "rs_defines.svh"

module tb_rs_top;
    import rs_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_ROWS     = 64;
    localparam int ROB_IDS      = 1 << `RS_ROBID_W;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   disp_valid;
    t_alu_op                disp_op;
    logic [`RS_ROBID_W-1:0] disp_robid;
    logic                   disp_src1_pending;
    logic [`RS_ROBID_W-1:0] disp_src1_robid;
    logic [`RS_XLEN-1:0]    disp_src1_val;
    logic                   disp_src2_pending;
    logic [`RS_ROBID_W-1:0] disp_src2_robid;
    logic [`RS_XLEN-1:0]    disp_src2_val;
    logic                   rs_full;
    logic                   res_valid;
    logic [`RS_ROBID_W-1:0] res_robid;
    logic [`RS_XLEN-1:0]    res_data;

    // Stimulus table with one row per micro-op
    string                  row_test  [MAX_ROWS];
    t_alu_op                row_op    [MAX_ROWS];
    logic [`RS_ROBID_W-1:0] row_robid [MAX_ROWS];
    // Producer row per source or -1 for a literal
    int                     row_prod  [MAX_ROWS][2];
    logic [`RS_XLEN-1:0]    row_lit   [MAX_ROWS][2];
    int                     row_idle  [MAX_ROWS];
    logic [`RS_XLEN-1:0]    row_exp   [MAX_ROWS];
    int                     row_done  [MAX_ROWS];
    int                     owner     [ROB_IDS];
    int                     n_rows = 0;
    int                     n_done = 0;
    logic                   table_ready = 1'b0;
    logic                   full_seen = 1'b0;
    logic [31:0]            rng_state = 32'd90831;

    rs_top u_rs_top (
        .clk               (clk),
        .reset             (reset),
        .disp_valid        (disp_valid),
        .disp_op           (disp_op),
        .disp_robid        (disp_robid),
        .disp_src1_pending (disp_src1_pending),
        .disp_src1_robid   (disp_src1_robid),
        .disp_src1_val     (disp_src1_val),
        .disp_src2_pending (disp_src2_pending),
        .disp_src2_robid   (disp_src2_robid),
        .disp_src2_val     (disp_src2_val),
        .rs_full           (rs_full),
        .res_valid         (res_valid),
        .res_robid         (res_robid),
        .res_data          (res_data)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Expected ALU behaviour with shifts by the low 5 bits of source 2
    function automatic logic [`RS_XLEN-1:0] alu_model(input t_alu_op op,
                                                      input logic [`RS_XLEN-1:0] a,
                                                      input logic [`RS_XLEN-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic add_row(input string test, input t_alu_op op,
                           input int p1, input logic [`RS_XLEN-1:0] v1,
                           input int p2, input logic [`RS_XLEN-1:0] v2, input int idle);
        logic [`RS_XLEN-1:0] a;
        logic [`RS_XLEN-1:0] b;
        a = (p1 >= 0) ? row_exp[p1] : v1;
        b = (p2 >= 0) ? row_exp[p2] : v2;
        row_test[n_rows]    = test;
        row_op[n_rows]      = op;
        row_robid[n_rows]   = n_rows % ROB_IDS;
        row_prod[n_rows][0] = p1;
        row_prod[n_rows][1] = p2;
        row_lit[n_rows][0]  = v1;
        row_lit[n_rows][1]  = v2;
        row_idle[n_rows]    = idle;
        row_exp[n_rows]     = alu_model(op, a, b);
        row_done[n_rows]    = 0;
        n_rows++;
    endtask

    task automatic build_table();
        int b;
        int p [2];
        for (int id = 0; id < ROB_IDS; id++) begin
            owner[id] = -1;
        end
        add_row("indep_ops", ALU_ADD, -1, 32'h1234_5678, -1, 32'h0fed_cba9, 0);
        add_row("indep_ops", ALU_SUB, -1, 32'h0000_0010, -1, 32'h0000_0020, 0);
        add_row("indep_ops", ALU_AND, -1, 32'hf0f0_a5a5, -1, 32'h3c3c_ffff, 1);
        add_row("indep_ops", ALU_OR,  -1, 32'h0101_0000, -1, 32'h0000_8080, 0);
        add_row("indep_ops", ALU_XOR, -1, 32'hdead_beef, -1, 32'hffff_0000, 3);
        add_row("indep_ops", ALU_SLL, -1, 32'h0000_00c3, -1, 32'h0000_0024, 0);
        add_row("indep_ops", ALU_SRL, -1, 32'h8000_0f00, -1, 32'hffff_ffe7, 0);
        // Consumers enter while their producers are still in flight
        b = n_rows;
        add_row("dep_chain", ALU_ADD, -1, 32'd100, -1, 32'd23, 5);
        add_row("dep_chain", ALU_SUB, b, '0, -1, 32'd3, 0);
        add_row("dep_chain", ALU_XOR, b + 1, '0, b, '0, 0);
        add_row("dep_chain", ALU_SLL, -1, 32'h1, b, '0, 0);
        add_row("dep_chain", ALU_OR,  b + 3, '0, b + 2, '0, 0);
        // Two idle cycles line the consumer up with the producer result
        b = n_rows;
        add_row("alloc_bypass", ALU_ADD, -1, 32'h0000_1111, -1, 32'h0000_2222, 16);
        add_row("alloc_bypass", ALU_SUB, b, '0, -1, 32'h0000_0333, 2);
        add_row("alloc_bypass", ALU_AND, -1, 32'h00ff_ff00, -1, 32'h0f0f_0f0f, 16);
        add_row("alloc_bypass", ALU_OR,  -1, 32'h1000_0001, b + 2, '0, 2);
        // Long chain followed by four waiters on its tail
        b = n_rows;
        add_row("fill_station", ALU_ADD, -1, 32'd7, -1, 32'd9, 16);
        add_row("fill_station", ALU_SLL, b, '0, -1, 32'd2, 0);
        add_row("fill_station", ALU_SUB, b + 1, '0, -1, 32'd5, 0);
        add_row("fill_station", ALU_XOR, b + 2, '0, -1, 32'h5555_aaaa, 0);
        add_row("fill_station", ALU_ADD, b + 3, '0, b + 3, '0, 0);
        add_row("fill_station", ALU_AND, b + 4, '0, -1, 32'hffff_00ff, 0);
        add_row("fill_station", ALU_OR,  -1, 32'h0100_0000, b + 4, '0, 0);
        add_row("fill_station", ALU_SRL, b + 4, '0, -1, 32'd3, 0);
        add_row("fill_station", ALU_SUB, -1, 32'd0, b + 4, '0, 0);
        b = n_rows;
        for (int k = 0; k < 32; k++) begin
            for (int s = 0; s < 2; s++) begin
                if (k > 0 && xorshift32() % 3 == 0) begin
                    p[s] = b + k - 1 - int'(xorshift32() % ((k < 4) ? k : 4));
                end else begin
                    p[s] = -1;
                end
            end
            add_row("random_b2b", t_alu_op'(3'(xorshift32() % 7)), p[0], xorshift32(),
                    p[1], xorshift32(), (k == 0) ? 16 : 0);
        end
    endtask

    // A dispatch still on the port may take the last free entry
    function automatic logic station_has_room();
        return !rs_full &&
               ($countones(u_rs_top.entry_valid) + int'(disp_valid) < `RS_NUM_ENTRIES);
    endfunction

    function automatic logic robid_free(input logic [`RS_ROBID_W-1:0] id);
        return owner[id] < 0 || row_done[owner[id]] > 0;
    endfunction

    task automatic dispatch_row(input int i);
        logic                   sent;
        logic                   room;
        int                     p;
        logic [1:0]             pend;
        logic [`RS_XLEN-1:0]    val    [2];
        logic [`RS_ROBID_W-1:0] src_id [2];
        sent = 1'b0;
        repeat (row_idle[i]) begin
            @(posedge clk);
            disp_valid <= 1'b0;
        end
        while (!sent) begin
            @(negedge clk);
            room = station_has_room();
            @(posedge clk);
            if (room && robid_free(row_robid[i])) begin
                for (int s = 0; s < 2; s++) begin
                    p         = row_prod[i][s];
                    pend[s]   = (p >= 0) && (row_done[p] == 0);
                    src_id[s] = (p >= 0) ? row_robid[p] : '0;
                    // Retired producer means the value comes from the register file
                    val[s]    = (p >= 0) ? (pend[s] ? '0 : row_exp[p]) : row_lit[i][s];
                end
                disp_valid        <= 1'b1;
                disp_op           <= row_op[i];
                disp_robid        <= row_robid[i];
                disp_src1_pending <= pend[0];
                disp_src1_robid   <= src_id[0];
                disp_src1_val     <= val[0];
                disp_src2_pending <= pend[1];
                disp_src2_robid   <= src_id[1];
                disp_src2_val     <= val[1];
                owner[row_robid[i]] = i;
                sent = 1'b1;
            end else begin
                disp_valid <= 1'b0;
            end
        end
    endtask

    task automatic check_completion();
        int r;
        r = owner[res_robid];
        assert (r >= 0 && row_done[r] == 0) else
            stop_on_error($sformatf("Unexpected completion for ROB id %0d", res_robid));
        assert (res_data == row_exp[r]) else
            stop_on_error($sformatf("[FAIL] %s: ROB id %0d expected %h actual %h",
                                    row_test[r], res_robid, row_exp[r], res_data));
        for (int s = 0; s < 2; s++) begin
            if (row_prod[r][s] >= 0) begin
                assert (row_done[row_prod[r][s]] > 0) else
                    stop_on_error($sformatf("ROB id %0d completed before its producer",
                                            res_robid));
            end
        end
        row_done[r]++;
        n_done++;
    endtask

    // Completion monitor samples at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (reset === 1'b0 && res_valid === 1'b1) begin
            check_completion();
        end
        if (rs_full === 1'b1) begin
            full_seen = 1'b1;
        end
    end

    initial begin
        wait (table_ready);
        repeat (40 * n_rows + RESET_CYCLES) @(posedge clk);
        stop_on_error($sformatf("Timeout with %0d of %0d micro-ops complete",
                                n_done, n_rows));
    end

    initial begin
        reset             = 1'b1;
        disp_valid        = 1'b0;
        disp_op           = ALU_ADD;
        disp_robid        = '0;
        disp_src1_pending = 1'b0;
        disp_src1_robid   = '0;
        disp_src1_val     = '0;
        disp_src2_pending = 1'b0;
        disp_src2_robid   = '0;
        disp_src2_val     = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (res_valid === 1'b0 && rs_full === 1'b0) else
                stop_on_error("res_valid or rs_full not low during reset");
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            assert (res_valid === 1'b0 && rs_full === 1'b0) else
                stop_on_error("res_valid or rs_full not low after reset");
        end
        for (int i = 0; i < n_rows; i++) begin
            dispatch_row(i);
        end
        @(posedge clk);
        disp_valid <= 1'b0;
        wait (n_done == n_rows);
        // Extra cycles to catch any late duplicate
        repeat (10) @(negedge clk);
        for (int i = 0; i < n_rows; i++) begin
            assert (row_done[i] == 1) else
                stop_on_error($sformatf("[FAIL] %s: ROB id %0d completions expected 1 actual %0d",
                                        row_test[i], row_robid[i], row_done[i]));
        end
        assert (full_seen) else
            stop_on_error("rs_full never rose while the station was being filled");
        $display(">>> PASS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
rs_pkg.sv
rs_issue_if.sv
rs_reg_trk.sv
rs_entry.sv
rs_alloc_ctl.sv
rs_issue_select.sv
rs_alu.sv
rs_top.sv
tb_rs_top.sv
